// File: verilog/avr_core_defines.svh
/*
 * Bus widths, sizes and reset values of the small AVR core.
 * Included by the RTL and by the testbench wherever one of them is needed.
 */
`ifndef AVR_CORE_DEFINES_SVH
`define AVR_CORE_DEFINES_SVH

`define AVR_PGM_ADDR_W  11      // Program memory word address
`define AVR_DATA_ADDR_W 12      // Data space address used by STS
`define AVR_IO_ADDR_W   6       // OUT reaches 64 I/O locations
`define AVR_WORD_W      16      // Instruction word

// Working registers r0 to r31
`define AVR_NUM_REGS    32

`define AVR_FLAG_COUNT  5       // C Z N V S, in SREG order

// Reset vector
`define AVR_PC_RESET    16'h0000

`endif

// File: verilog/avr_core_pkg.sv
/*
 * Types shared by the core modules and the testbench.
 * Bus fields follow the widths in the defines header.
 */
`include "avr_core_defines.svh"

package avr_core_pkg;

	typedef enum logic {
		STEP1,
		STEP2           // Second word of JMP or STS
	} step_t;

	typedef enum logic [3:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_AND,
		ALU_EOR,
		ALU_OR,
		ALU_MOV
	} alu_op_t;

	typedef enum logic [1:0] {
		PC_INC,
		PC_HOLD,
		PC_REL,         // pc + 1 + signed offset
		PC_ABS
	} pc_cmd_t;

	// Declared high to low so c lands on bit 0 as in SREG
	typedef struct packed {
		logic s;
		logic v;
		logic n;
		logic z;
		logic c;
	} flags_t;

	typedef struct packed {
		logic       en;
		logic [4:0] addr;
		logic [7:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic                      we;
		logic [`AVR_IO_ADDR_W-1:0] addr;
		logic [7:0]                data;
	} io_wr_t;

	typedef struct packed {
		logic                        we;
		logic [`AVR_DATA_ADDR_W-1:0] addr;
		logic [7:0]                  data;
	} data_wr_t;

endpackage

// File: verilog/avr_alu.sv
/*
 * 8-bit ALU for the register-register operations and the status flags.
 * Result is combinational; flags change on the edge ending an ADD to OR.
 */
`timescale 1ns/1ps

module avr_alu (
	input  logic                  clk,
	input  logic                  rst,
	input  avr_core_pkg::alu_op_t op,
	input  logic [7:0]            a,
	input  logic [7:0]            b,
	output logic [7:0]            result,
	output avr_core_pkg::flags_t  flags
);
	import avr_core_pkg::*;

	logic [8:0] sum;        // Bit 8 is carry, or borrow for SUB
	logic       arith;
	logic       ovf;
	logic       upd;
	flags_t     next_flags;

	always_comb
	begin
		sum = {1'b0, a} + {1'b0, b};
		arith = 1'b1;
		result = b;         // MOV, and idle
		case (op)
			ALU_ADD: result = sum[7:0];
			ALU_ADC:
			begin
				sum = {1'b0, a} + {1'b0, b} + {8'd0, flags.c};
				result = sum[7:0];
			end
			ALU_SUB:
			begin
				sum = {1'b0, a} - {1'b0, b};
				result = sum[7:0];
			end
			ALU_AND: result = a & b;
			ALU_EOR: result = a ^ b;
			ALU_OR:  result = a | b;
			default: ;
		endcase
		if (!(op inside {ALU_ADD, ALU_ADC, ALU_SUB}))
			arith = 1'b0;
	end

	always_comb
	begin
		if (op == ALU_SUB)
			ovf = (a[7] & ~b[7] & ~result[7]) | (~a[7] & b[7] & result[7]);
		else
			ovf = (a[7] & b[7] & ~result[7]) | (~a[7] & ~b[7] & result[7]);

		next_flags.c = arith ? sum[8] : flags.c;   // Logic ops keep C
		next_flags.v = arith & ovf;
		next_flags.z = (result == 8'h00);
		next_flags.n = result[7];
		next_flags.s = next_flags.n ^ next_flags.v;
	end

	assign upd = op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_AND, ALU_EOR, ALU_OR};

	always_ff @(posedge clk)
	begin
		if (rst)
			flags <= '0;
		else if (upd)
			flags <= next_flags;
	end

endmodule

// File: verilog/avr_regfile.sv
/*
 * Working registers r0 to r31.
 * Two asynchronous read ports for Rd and Rr, one write port on the clock edge.
 */
`timescale 1ns/1ps
`include "avr_core_defines.svh"

module avr_regfile (
	input  logic                  clk,
	input  avr_core_pkg::reg_wr_t wr,
	input  logic [4:0]            rd_d_addr,
	input  logic [4:0]            rd_r_addr,
	output logic [7:0]            rd_d,
	output logic [7:0]            rd_r
);

	logic [7:0] regs [`AVR_NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (wr.en)
			regs[wr.addr] <= wr.data;
	end

	// Same-cycle write is not forwarded
	assign rd_d = regs[rd_d_addr];
	assign rd_r = regs[rd_r_addr];

endmodule

// File: verilog/avr_pc.sv
/*
 * Program counter in words.
 * The sequencer picks increment, hold, relative jump or absolute load each cycle.
 */
`timescale 1ns/1ps
`include "avr_core_defines.svh"

module avr_pc (
	input  logic                  clk,
	input  logic                  rst,
	input  avr_core_pkg::pc_cmd_t cmd,
	input  logic [15:0]           arg,
	output logic [15:0]           pc
);
	import avr_core_pkg::*;

	logic [15:0] pc_inc;

	// Shared by the plain step and the relative form
	assign pc_inc = pc + 16'd1;

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= `AVR_PC_RESET;
		else
		begin
			case (cmd)
				PC_INC:  pc <= pc_inc;
				PC_HOLD: pc <= pc;
				PC_REL:  pc <= pc_inc + arg;    // arg is sign extended already
				PC_ABS:  pc <= arg;
				default: pc <= pc_inc;
			endcase
		end
	end

endmodule

// File: verilog/avr_sequencer.sv
/*
 * Instruction decoder and step sequencer of the core.
 * One-word instructions finish in STEP1; JMP and STS take a second step
 * while the program memory returns their second word.
 */
`timescale 1ns/1ps
`include "avr_core_defines.svh"

module avr_sequencer (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`AVR_WORD_W-1:0]   pgm_data,
	input  avr_core_pkg::flags_t     flags,
	input  logic [7:0]               rd_d,
	input  logic [7:0]               rd_r,
	input  logic [7:0]               alu_result,
	output logic [4:0]               rd_d_addr,
	output logic [4:0]               rd_r_addr,
	output avr_core_pkg::alu_op_t    alu_op,
	output logic [7:0]               alu_a,
	output logic [7:0]               alu_b,
	output avr_core_pkg::reg_wr_t    reg_wr,
	output avr_core_pkg::pc_cmd_t    pc_cmd,
	output logic [15:0]              pc_arg,
	output avr_core_pkg::io_wr_t     io_wr,
	output avr_core_pkg::data_wr_t   data_wr
);
	import avr_core_pkg::*;

	step_t                 step;
	step_t                 next_step;
	logic [`AVR_WORD_W-1:0] first_word;     // JMP or STS opcode word
	logic [`AVR_WORD_W-1:0] ir;             // Word whose register fields are in use
	logic [7:0]            flag_vec;
	logic                  flag_bit;

	assign ir = (step == STEP2) ? first_word : pgm_data;

	// s values past the last flag read as 0
	assign flag_vec = {{(8 - `AVR_FLAG_COUNT){1'b0}}, flags};
	assign flag_bit = flag_vec[pgm_data[2:0]];

	assign rd_d_addr = ir[8:4];
	assign rd_r_addr = {ir[9], ir[3:0]};
	assign alu_a = rd_d;
	assign alu_b = rd_r;

	always_comb
	begin
		next_step = STEP1;
		alu_op = ALU_NONE;
		pc_cmd = PC_INC;
		pc_arg = '0;
		reg_wr = '{en: 1'b0, addr: ir[8:4], data: alu_result};
		io_wr = '{we: 1'b0, addr: {pgm_data[10:9], pgm_data[3:0]}, data: rd_d};
		data_wr = '{we: 1'b0, addr: pgm_data[`AVR_DATA_ADDR_W-1:0], data: rd_d};

		if (step == STEP2)
		begin
			// Bit 10 separates JMP (1001 010x) from STS (1001 001x)
			if (first_word[10])
			begin
				pc_cmd = PC_ABS;
				pc_arg = pgm_data;
			end
			else
				data_wr.we = 1'b1;
		end
		else
		begin
			casez (pgm_data)
				16'b0000_11??_????_????: alu_op = ALU_ADD;
				16'b0001_11??_????_????: alu_op = ALU_ADC;
				16'b0001_10??_????_????: alu_op = ALU_SUB;
				16'b0010_00??_????_????: alu_op = ALU_AND;
				16'b0010_01??_????_????: alu_op = ALU_EOR;
				16'b0010_10??_????_????: alu_op = ALU_OR;
				16'b0010_11??_????_????: alu_op = ALU_MOV;
				16'b1110_????_????_????:    // LDI into r16..r31
				begin
					reg_wr.en = 1'b1;
					reg_wr.addr = {1'b1, pgm_data[7:4]};
					reg_wr.data = {pgm_data[11:8], pgm_data[3:0]};
				end
				16'b1100_????_????_????:    // RJMP
				begin
					pc_cmd = PC_REL;
					pc_arg = {{4{pgm_data[11]}}, pgm_data[11:0]};
				end
				16'b1111_0???_????_????:    // BRBS when bit 10 is 0, BRBC when 1
				begin
					if (flag_bit != pgm_data[10])
					begin
						pc_cmd = PC_REL;
						pc_arg = {{9{pgm_data[9]}}, pgm_data[9:3]};
					end
				end
				16'b1011_1???_????_????: io_wr.we = 1'b1;    // OUT
				16'b1001_010?_????_110?,                      // JMP
				16'b1001_001?_????_0000: next_step = STEP2;  // STS
				default: ;                                    // Anything else is a NOP
			endcase

			if (alu_op != ALU_NONE)
				reg_wr.en = 1'b1;
		end

		// Program memory is live during reset
		reg_wr.en = reg_wr.en & ~rst;
		io_wr.we = io_wr.we & ~rst;
		data_wr.we = data_wr.we & ~rst;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			step <= STEP1;
		else
			step <= next_step;
	end

	always_ff @(posedge clk)
	begin
		if (next_step == STEP2)
			first_word <= pgm_data;
	end

endmodule

// File: verilog/avr_core.sv
/*
 * Top level of the small AVR core.
 * Connect pgm_addr/pgm_data to a combinational program ROM; io_wr and data_wr
 * are one-cycle write strobes with address and data.
 */
`timescale 1ns/1ps
`include "avr_core_defines.svh"

module avr_core (
	input  logic                        clk,
	input  logic                        rst,
	output logic [`AVR_PGM_ADDR_W-1:0]  pgm_addr,
	input  logic [`AVR_WORD_W-1:0]      pgm_data,
	output avr_core_pkg::io_wr_t        io_wr,
	output avr_core_pkg::data_wr_t      data_wr
);
	import avr_core_pkg::*;

	flags_t      flags;
	alu_op_t     alu_op;
	pc_cmd_t     pc_cmd;
	reg_wr_t     reg_wr;
	logic [4:0]  rd_d_addr;
	logic [4:0]  rd_r_addr;
	logic [7:0]  rd_d;
	logic [7:0]  rd_r;
	logic [7:0]  alu_a;
	logic [7:0]  alu_b;
	logic [7:0]  alu_result;
	logic [15:0] pc_arg;
	logic [15:0] pc;

	assign pgm_addr = pc[`AVR_PGM_ADDR_W-1:0];     // Upper pc bits run past the ROM

	avr_sequencer u_seq (
		.clk(clk), .rst(rst), .pgm_data(pgm_data), .flags(flags),
		.rd_d(rd_d), .rd_r(rd_r), .alu_result(alu_result),
		.rd_d_addr(rd_d_addr), .rd_r_addr(rd_r_addr),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
		.reg_wr(reg_wr), .pc_cmd(pc_cmd), .pc_arg(pc_arg),
		.io_wr(io_wr), .data_wr(data_wr)
	);

	avr_pc u_pc (.clk(clk), .rst(rst), .cmd(pc_cmd), .arg(pc_arg), .pc(pc));

	avr_regfile u_regs (
		.clk(clk), .wr(reg_wr),
		.rd_d_addr(rd_d_addr), .rd_r_addr(rd_r_addr),
		.rd_d(rd_d), .rd_r(rd_r)
	);

	avr_alu u_alu (
		.clk(clk), .rst(rst), .op(alu_op), .a(alu_a), .b(alu_b),
		.result(alu_result), .flags(flags)
	);

endmodule

// File: tests/avr_core_tb.sv
/*
 * Testbench for the small AVR core. Builds each test program in a ROM,
 * runs an instruction-level model over it and checks every OUT and STS write.
 */
`timescale 1ns/1ps
`include "avr_core_defines.svh"

module avr_core_tb;
	import avr_core_pkg::*;

	typedef logic [`AVR_PGM_ADDR_W-1:0] paddr_t;

	// ADD ADC SUB AND EOR OR MOV, six opcode bits each
	localparam logic [41:0] opc_tab = {6'b001011, 6'b001010, 6'b001001, 6'b001000,
		6'b000110, 6'b000111, 6'b000011};

	logic                   clk;
	logic                   rst;
	paddr_t                 pgm_addr;
	logic [`AVR_WORD_W-1:0] pgm_data;
	io_wr_t                 io_wr;
	data_wr_t               data_wr;

	logic [`AVR_WORD_W-1:0] rom [2**`AVR_PGM_ADDR_W];
	logic [7:0]             m_regs [`AVR_NUM_REGS];     // Model copy of r0..r31
	paddr_t                 m_pc;
	logic                   m_c, m_z, m_n, m_v, m_s;
	io_wr_t                 exp_io [$];
	data_wr_t               exp_dw [$];
	paddr_t                 exp_pc [$];                 // Fetch address of every cycle
	io_wr_t                 io_head;
	data_wr_t               dw_head;
	paddr_t                 pc_head;
	logic [31:0]            lcg_state = 32'h475f_e918;
	int                     wp;                         // ROM write pointer
	paddr_t                 halt_pc;
	int                     errs;
	int                     n_pass;
	int                     n_fail;
	time                    deadline;
	string                  names [5] = '{"LDI and OUT", "random ALU", "flag branches",
		"RJMP loop", "STS and JMP"};

	avr_core DUT (
		.clk(clk), .rst(rst), .pgm_addr(pgm_addr), .pgm_data(pgm_data),
		.io_wr(io_wr), .data_wr(data_wr)
	);

	assign pgm_data = rom[pgm_addr];    // Combinational program memory

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rnd(input int n);
		return int'(lcg_next() >> 8) % n;
	endfunction

	function automatic logic [15:0] enc_alu(input int op, input int d, input int r);
		logic [5:0] opc;
		opc = opc_tab[6*op +: 6];
		return {opc, r[4], d[4:0], r[3:0]};
	endfunction

	function automatic logic [15:0] enc_ldi(input int d, input int k);
		return {4'hE, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic logic [15:0] enc_out(input int a, input int r);
		return {5'b10111, a[5:4], r[4:0], a[3:0]};
	endfunction

	function automatic logic [15:0] enc_rjmp(input int off);
		return {4'hC, off[11:0]};
	endfunction

	// set = 1 gives BRBS, set = 0 gives BRBC
	function automatic logic [15:0] enc_br(input int set, input int s, input int off);
		return {5'b11110, ~set[0], off[6:0], s[2:0]};
	endfunction

	task automatic put(input logic [15:0] w);
		rom[paddr_t'(wp)] = w;
		wp++;
	endtask

	// Runs the instruction at m_pc and queues the bus write it makes, if any
	function automatic void exec_one();
		logic [15:0] w;
		logic [4:0]  d;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [8:0]  wide;
		logic [7:0]  res;
		logic        fbit;
		logic        upd;
		w = rom[m_pc];
		exp_pc.push_back(m_pc);
		d = w[8:4];
		a = m_regs[d];
		b = m_regs[{w[9], w[3:0]}];
		upd = 1'b1;
		fbit = 1'b0;
		m_pc = m_pc + paddr_t'(1);
		case (w[15:10])
			6'b000011, 6'b000111:   // ADD, ADC
			begin
				wide = {1'b0, a} + {1'b0, b} + {8'd0, w[12] & m_c};
				res = wide[7:0];
				m_c = wide[8];
				m_v = (a[7] == b[7]) && (res[7] != a[7]);
			end
			6'b000110:
			begin
				res = a - b;
				m_c = b > a;        // Borrow
				m_v = (a[7] != b[7]) && (res[7] != a[7]);
			end
			6'b001000, 6'b001001, 6'b001010:
			begin
				res = (w[11:10] == 2'b00) ? (a & b) : (w[10] ? (a ^ b) : (a | b));
				m_v = 1'b0;
			end
			default:
			begin
				upd = 1'b0;
				res = b;
				if (w[15:10] == 6'b001011)
					m_regs[d] = b;
				else if (w[15:12] == 4'hE)
					m_regs[{1'b1, w[7:4]}] = {w[11:8], w[3:0]};
				else if (w[15:12] == 4'hC)
					m_pc = m_pc + paddr_t'($signed(w[11:0]));
				else if (w[15:11] == 5'b11110)
				begin
					case (w[2:0])
						3'd0: fbit = m_c;
						3'd1: fbit = m_z;
						3'd2: fbit = m_n;
						3'd3: fbit = m_v;
						3'd4: fbit = m_s;
						default: fbit = 1'b0;
					endcase
					// BRBS jumps on a set flag and BRBC on a clear one
					if (w[10] ? !fbit : fbit)
						m_pc = m_pc + paddr_t'($signed(w[9:3]));
				end
				else if (w[15:11] == 5'b10111)
					exp_io.push_back(io_wr_t'{we: 1'b1, addr: {w[10:9], w[3:0]}, data: a});
				else if (w[15:9] == 7'b1001010 && w[3:1] == 3'b110)
				begin
					exp_pc.push_back(m_pc);     // Second word fetched in STEP2
					m_pc = rom[m_pc][`AVR_PGM_ADDR_W-1:0];
				end
				else if (w[15:9] == 7'b1001001 && w[3:0] == 4'h0)
				begin
					exp_pc.push_back(m_pc);
					exp_dw.push_back(data_wr_t'{we: 1'b1,
						addr: rom[m_pc][`AVR_DATA_ADDR_W-1:0], data: a});
					m_pc = m_pc + paddr_t'(1);
				end
			end
		endcase
		if (upd)
		begin
			m_regs[d] = res;
			m_z = (res == 8'd0);
			m_n = res[7];
			m_s = m_n ^ m_v;
		end
	endfunction

	function automatic int run_model();
		int n;
		n = 0;
		m_pc = '0;
		{m_c, m_z, m_n, m_v, m_s} = 5'b0;     // Flags come out of reset cleared
		while (m_pc != halt_pc && n < 4000)
		begin
			exec_one();
			n++;
		end
		return n;
	endfunction

	task automatic build_test(input int t);
		int i;
		int s;
		int d;
		int top;
		wp = 0;
		if (t > 0)
			for (i = 16; i < 32; i++)
				put(enc_ldi(i, rnd(256)));
		case (t)
			0:
				for (i = 0; i < 6; i++)
				begin
					d = 16 + rnd(16);
					put(enc_ldi(d, rnd(256)));
					put(enc_out(rnd(64), d));
				end
			1:
				for (i = 0; i < 16; i++)
				begin
					d = 16 + rnd(16);
					put(enc_alu(rnd(7), d, 16 + rnd(16)));
					put(enc_out(rnd(64), d));
				end
			2:
				for (i = 0; i < 8; i++)
				begin
					d = 16 + rnd(16);
					put(enc_alu(rnd(6), d, 16 + rnd(16)));
					for (s = 0; s < 5; s++)
					begin
						put(enc_br(rnd(2), s, 1));
						put(enc_out(32 + s, d));    // Marker when not taken
					end
				end
			3:
			begin
				put(enc_ldi(16, 2 + rnd(4)));   // Loop count
				put(enc_ldi(17, 1));
				top = wp;
				put(enc_alu(0, 19, 18));
				put(enc_out(rnd(64), 19));
				put(enc_rjmp(1));
				put(enc_out(63, 16));           // Jumped over
				put(enc_alu(2, 16, 17));
				put(enc_br(1, 1, 1));           // Leave the loop once Z is set
				put(enc_rjmp(top - wp - 1));
			end
			default:
			begin
				d = 16 + rnd(16);
				put(enc_ldi(d, rnd(256)));
				put({7'b1001001, 5'(d), 4'h0});
				put(16'(rnd(4096)));
				put(16'h940C);
				put(16'(wp + 4));
				for (i = 0; i < 3; i++)
					put(enc_out(rnd(64), d));
				put(enc_out(rnd(64), d));       // JMP target
				d = 16 + rnd(16);
				put({7'b1001001, 5'(d), 4'h0});
				put(16'(rnd(4096)));
			end
		endcase
		halt_pc = paddr_t'(wp);
		put(16'hCFFF);                          // RJMP to itself
	endtask

	// Checks the fetch address of every cycle and each bus write against the model
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (exp_pc.size() > 0)
				pc_head = exp_pc.pop_front();
			else
				pc_head = halt_pc;      // Parked on the final RJMP
			assert (pgm_addr == pc_head)
			else
			begin
				$display("FAIL %0t pgm_addr expected %h actual %h", $time, pc_head, pgm_addr);
				errs++;
			end
		end
		if (io_wr.we)
		begin
			assert (exp_io.size() > 0)
			else
			begin
				$display("%0t: OUT to 0x%h was not expected by the model", $time, io_wr.addr);
				errs++;
			end
			if (exp_io.size() > 0)
			begin
				io_head = exp_io.pop_front();
				assert (io_wr == io_head)
				else
				begin
					$display("FAIL %0t io_wr expected %h actual %h", $time, io_head, io_wr);
					errs++;
				end
			end
		end
		if (data_wr.we)
		begin
			assert (exp_dw.size() > 0)
			else
			begin
				$display("%0t: STS to 0x%h was not expected by the model", $time, data_wr.addr);
				errs++;
			end
			if (exp_dw.size() > 0)
			begin
				dw_head = exp_dw.pop_front();
				assert (data_wr == dw_head)
				else
				begin
					$display("FAIL %0t data_wr expected %h actual %h", $time, dw_head, data_wr);
					errs++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		if (deadline != 0 && $time > deadline)
		begin
			$display("Timeout: the DUT did not reach the end of the test program");
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial
	begin
		int t;
		int n_instr;
		int n_io;
		int n_dw;
		clk = 1'b0;
		rst = 1'b1;
		errs = 0;
		n_pass = 0;
		n_fail = 0;
		deadline = 0;
		for (t = 0; t < 5; t++)
		begin
			@(posedge clk);
			rst <= 1'b1;
			@(posedge clk);
			exp_io.delete();
			exp_dw.delete();
			exp_pc.delete();
			errs = 0;
			build_test(t);
			n_instr = run_model();
			assert (m_pc == halt_pc)
			else
			begin
				$display("Reference model never reached the end of test %0d", t + 1);
				errs++;
			end
			n_io = exp_io.size();
			n_dw = exp_dw.size();
			repeat (9) @(posedge clk);
			rst <= 1'b0;
			deadline = $time + 64'(8 * n_instr + 200);
			@(negedge clk);
			while (pgm_addr != halt_pc)
				@(negedge clk);
			deadline = 0;
			assert (exp_io.size() == 0 && exp_dw.size() == 0 && exp_pc.size() == 0)
			else
			begin
				$display("%0d OUT writes, %0d STS writes and %0d fetches never appeared",
					exp_io.size(), exp_dw.size(), exp_pc.size());
				errs++;
			end
			$display("Test %0d (%s): %0d OUT and %0d STS writes, %0d errors", t + 1,
				names[t], n_io, n_dw, errs);
			if (errs == 0)
				n_pass++;
			else
				n_fail++;
		end
		$display("Tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: avr_core.f
+incdir+verilog
verilog/avr_core_pkg.sv
verilog/avr_alu.sv
verilog/avr_regfile.sv
verilog/avr_pc.sv
verilog/avr_sequencer.sv
verilog/avr_core.sv
tests/avr_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert -j 0
TOP       = avr_core_tb
FLIST     = avr_core.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SRCS = $(shell grep -v '^+' $(FLIST))
HDRS = $(wildcard verilog/*.svh)
SIM  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG) || ! grep -qF '*** TEST PASSED ***' $(LOG); \
	then echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
